// ==== files.f ====
source/dp_video_pkg.sv
source/dp_link_pkg.sv
source/td_config_capture.sv
source/h_symbol_calc.sv
source/seq_divider.sv
source/tu_size_calc.sv
source/td_output_stage.sv
source/timing_decision_top.sv
verif/timing_decision_assertions.sv
verif/tb_timing_decision.sv

// ==== run.sh ====
#!/bin/sh
# compile the timing decision testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_timing_decision -f files.f -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_timing_decision)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// ==== source/dp_link_pkg.sv ====
// link side definitions
// lane count encoding, transfer unit size, divider and control states
package dp_link_pkg;

    // log2 of the active lane count, 1/2/4 lanes -> 0/1/2
    typedef logic [1:0] lane_shift_t;

    // transfer unit
    localparam int TU_SIZE = 64;  // symbols per transfer unit
    localparam int TU_W    = 6;   // width of valid and stuffed sizes

    // sequential divider states
    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_e;

    // calculation control
    typedef enum logic [1:0] {
        st_idle,   // waiting for attributes, bandwidth and iso start
        st_calc,   // one cycle, drives calc_start
        st_hold    // results held, waiting for new attributes
    } calc_state_e;

endpackage

// ==== source/dp_video_pkg.sv ====
// video side definitions
// decoded pixel formats, misc format codes, symbols per pixel
// and the field widths of the horizontal and vertical counters
package dp_video_pkg;

    // decoded pixel format, five codes need three bits
    typedef enum logic [2:0] {
        rgb_8,
        rgb_16,
        ycc444_8,
        ycc444_16,
        other_fmt
    } pix_fmt_e;

    // format code is {misc1[7:6], misc0[7:1]}
    localparam logic [8:0] MISC_RGB_8     = 9'h010;
    localparam logic [8:0] MISC_RGB_16    = 9'h040;
    localparam logic [8:0] MISC_YCC444_8  = 9'h016;
    localparam logic [8:0] MISC_YCC444_16 = 9'h046;

    // symbols per pixel, one symbol is one byte
    localparam logic [15:0] BYTES_PER_PIXEL_8  = 16'd3;  // 3 comps x 8 bit
    localparam logic [15:0] BYTES_PER_PIXEL_16 = 16'd6;  // 3 comps x 16 bit

    //==================================================
    // counter field widths
    //==================================================
    localparam int H_WIDTH_W = 16;  // hactive, htotal
    localparam int HBLANK_W  = 14;
    localparam int VBLANK_W  = 10;
    localparam int VACTIVE_W = 13;

endpackage

// ==== source/h_symbol_calc.sv ====
`timescale 1ns/1ps
// horizontal active and blanking symbol counts per lane
// three stage pipeline: shift and remainder, round up, scale by bpp
module h_symbol_calc
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                calc_start,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  hwidth_q,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  htotal_q,
    input  logic [15:0]                         bytes_per_pixel,
    input  dp_link_pkg::lane_shift_t            lane_shift,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  hactive_sym,
    output logic [dp_video_pkg::HBLANK_W-1:0]   hblank_sym,
    output logic                                h_done
);
    import dp_video_pkg::*;

    logic [H_WIDTH_W-1:0] hblank_w;    // htotal - hwidth
    logic [H_WIDTH_W-1:0] lane_mask;   // bits dropped by the lane shift
    logic [H_WIDTH_W-1:0] act_q1;
    logic [H_WIDTH_W-1:0] blk_q1;
    logic                 act_r1;      // nonzero remainder, round up later
    logic                 blk_r1;
    logic [H_WIDTH_W-1:0] act_q2;
    logic [H_WIDTH_W-1:0] blk_q2;
    logic [31:0]          act_prod;
    logic [31:0]          blk_prod;
    logic [2:0]           vld;         // one valid bit per stage

    assign hblank_w  = htotal_q - hwidth_q;
    assign lane_mask = (H_WIDTH_W'(1) << lane_shift) - 1'b1;
    assign act_prod  = 32'(act_q2) * 32'(bytes_per_pixel);
    assign blk_prod  = 32'(blk_q2) * 32'(bytes_per_pixel);
    assign h_done    = vld[2];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            vld <= '0;
        else
            vld <= {vld[1:0], calc_start};   // back to back starts stay in flight
    end

    //==================================================
    // datapath
    //==================================================
    always_ff @(posedge clk)
    begin
        if (calc_start)
        begin
            act_q1 <= hwidth_q >> lane_shift;
            act_r1 <= |(hwidth_q & lane_mask);
            blk_q1 <= hblank_w >> lane_shift;
            blk_r1 <= |(hblank_w & lane_mask);
        end
        if (vld[0])                          // ceil of the division
        begin
            act_q2 <= act_q1 + H_WIDTH_W'(act_r1);
            blk_q2 <= blk_q1 + H_WIDTH_W'(blk_r1);
        end
        if (vld[1])
        begin
            hactive_sym <= act_prod[H_WIDTH_W-1:0];
            hblank_sym  <= blk_prod[HBLANK_W-1:0];   // fits blanking field
        end
    end

endmodule

// ==== source/seq_divider.sv ====
`timescale 1ns/1ps
// restoring divider, one quotient bit per cycle
// done pulses WIDTH+1 cycles after an accepted start
module seq_divider #(
    parameter int WIDTH = 20
)
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,      // ignored while busy
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic [WIDTH-1:0] quotient,   // held until the next start
    output logic             done
);
    import dp_link_pkg::*;

    localparam int CNT_W = $clog2(WIDTH + 1);

    div_state_e       state;
    logic [CNT_W-1:0] bit_cnt;    // quotient bits still to go
    logic [WIDTH-1:0] rem;        // partial remainder
    logic [WIDTH-1:0] dvsr;       // divisor latched at start
    logic [WIDTH:0]   trial;      // shifted remainder minus divisor

    // quotient register doubles as the dividend shift register
    assign trial = {rem, quotient[WIDTH-1]} - {1'b0, dvsr};
    assign done  = (state == div_done);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= div_idle;
            bit_cnt <= '0;
        end
        else if (state == div_busy)
        begin
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == CNT_W'(1))
                state <= div_done;
        end
        else if (start)                       // idle or done
        begin
            state   <= div_busy;
            bit_cnt <= CNT_W'(WIDTH);
        end
        else
            state <= div_idle;
    end

    always_ff @(posedge clk)
    begin
        if (state != div_busy && start)
        begin
            rem      <= '0;
            quotient <= dividend;
            dvsr     <= divisor;
        end
        else if (state == div_busy)
        begin
            if (!trial[WIDTH])                // fits, keep difference
            begin
                rem      <= trial[WIDTH-1:0];
                quotient <= {quotient[WIDTH-2:0], 1'b1};
            end
            else                              // restore
            begin
                rem      <= {rem[WIDTH-2:0], quotient[WIDTH-1]};
                quotient <= {quotient[WIDTH-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== source/td_config_capture.sv ====
`timescale 1ns/1ps
// capture of main stream attributes, lane settings and stream bandwidth
// pixel format decode into symbols per pixel, lane count to shift
// control FSM driving calc_start and calc_clear
module td_config_capture
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                spm_msa_vld,      // attributes strobe
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  htotal,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  hwidth,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  vtotal,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  vheight,
    input  logic [7:0]                          misc0,
    input  logic [7:0]                          misc1,
    input  logic                                spm_iso_start,
    input  logic [2:0]                          spm_lane_count,   // 1, 2 or 4
    input  logic [15:0]                         spm_lane_bw,
    input  logic [9:0]                          ms_stm_bw,
    input  logic                                ms_stm_bw_valid,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  hwidth_q,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  htotal_q,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  vtotal_q,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  vheight_q,
    output logic [15:0]                         bytes_per_pixel,
    output dp_link_pkg::lane_shift_t            lane_shift,
    output logic [15:0]                         lane_bw_q,
    output logic [9:0]                          stream_bw_q,
    output logic                                calc_start,       // one cycle pulse
    output logic                                calc_clear,       // level, iso start low
    output logic [2:0]                          lane_count_q
);
    import dp_video_pkg::*;
    import dp_link_pkg::*;

    logic [8:0]  misc_q;     // captured format code
    logic        msa_seen;   // attributes captured at least once
    logic        bw_seen;    // stream bandwidth captured at least once
    logic        iso_d;
    logic        iso_rise;
    logic        calc_ready;
    pix_fmt_e    pix_fmt;
    calc_state_e state;

    assign iso_rise   = spm_iso_start & ~iso_d;
    assign calc_ready = msa_seen & bw_seen & spm_iso_start;
    assign calc_clear = ~spm_iso_start;
    assign calc_start = (state == st_calc);

    // payload capture
    always_ff @(posedge clk)
    begin
        if (spm_msa_vld)
        begin
            htotal_q  <= htotal;
            hwidth_q  <= hwidth;
            vtotal_q  <= vtotal;
            vheight_q <= vheight;
            misc_q    <= {misc1[7:6], misc0[7:1]};
        end
        if (iso_rise)                    // link settings only on iso start edge
        begin
            lane_bw_q    <= spm_lane_bw;
            lane_count_q <= spm_lane_count;
        end
        if (ms_stm_bw_valid)
            stream_bw_q <= ms_stm_bw;
    end

    //==================================================
    // control FSM
    //==================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            msa_seen <= 1'b0;
            bw_seen  <= 1'b0;
            iso_d    <= 1'b0;
            state    <= st_idle;
        end
        else
        begin
            iso_d <= spm_iso_start;
            if (spm_msa_vld)
                msa_seen <= 1'b1;
            if (ms_stm_bw_valid)
                bw_seen <= 1'b1;
            if (!spm_iso_start)
                state <= st_idle;             // iso drop aborts everything
            else if (state == st_idle && calc_ready)
                state <= st_calc;
            else if (state == st_calc)
                state <= st_hold;
            else if (state == st_hold && spm_msa_vld)
                state <= st_calc;             // new attributes restart the calc
        end
    end

    // format decode, anything but the two 16 bpc codes runs as 8 bpc
    always_comb
    begin
        case (misc_q)
            MISC_RGB_8:     pix_fmt = rgb_8;
            MISC_RGB_16:    pix_fmt = rgb_16;
            MISC_YCC444_8:  pix_fmt = ycc444_8;
            MISC_YCC444_16: pix_fmt = ycc444_16;
            default:        pix_fmt = other_fmt;
        endcase
        if (pix_fmt == rgb_16 || pix_fmt == ycc444_16)
            bytes_per_pixel = BYTES_PER_PIXEL_16;
        else
            bytes_per_pixel = BYTES_PER_PIXEL_8;
        case (lane_count_q)
            3'd4:    lane_shift = 2'd2;
            3'd2:    lane_shift = 2'd1;
            default: lane_shift = 2'd0;   // single lane
        endcase
    end

endmodule

// ==== source/td_output_stage.sv ====
`timescale 1ns/1ps
// joins horizontal and TU results into the timing outputs
// sticky done flags, vertical blank, htotal, stuffed size, lane encoding
module td_output_stage
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                calc_start,
    input  logic                                calc_clear,
    input  logic                                h_done,
    input  logic                                tu_done,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  hactive_sym,
    input  logic [dp_video_pkg::HBLANK_W-1:0]   hblank_sym,
    input  logic [dp_link_pkg::TU_W-1:0]        tu_valid_size,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  vtotal_q,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  vheight_q,
    input  logic [2:0]                          lane_count_q,
    output logic                                td_vld_data,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  td_h_active_ctr,
    output logic [dp_video_pkg::HBLANK_W-1:0]   td_h_blank_ctr,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  td_h_total_ctr,
    output logic [dp_video_pkg::VBLANK_W-1:0]   td_v_blank_ctr,
    output logic [dp_video_pkg::VACTIVE_W-1:0]  td_v_active_ctr,
    output logic [1:0]                          td_lane_count,
    output logic [dp_link_pkg::TU_W-1:0]        td_tu_vld_data_size,
    output logic [dp_link_pkg::TU_W-1:0]        td_tu_stuffed_data_size
);
    import dp_video_pkg::*;
    import dp_link_pkg::*;

    logic                 h_seen;      // sticky h_done
    logic                 tu_seen;     // sticky tu_done
    logic                 vld_q;
    logic                 both_done;
    logic [H_WIDTH_W-1:0] vblank_full;
    logic [H_WIDTH_W-1:0] htotal_sym;
    logic [TU_W-1:0]      stuff_size;
    logic [2:0]           lane_m1;

    // include this cycle's pulses so the load lands one cycle after the later one
    assign both_done   = (h_seen | h_done) & (tu_seen | tu_done);
    assign vblank_full = vtotal_q - vheight_q;
    assign htotal_sym  = hactive_sym + H_WIDTH_W'(hblank_sym);
    assign stuff_size  = TU_W'(TU_SIZE - tu_valid_size);
    assign lane_m1     = lane_count_q - 3'd1;
    assign td_vld_data = vld_q & ~calc_start;    // low during a restart

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_seen                  <= 1'b0;
            tu_seen                 <= 1'b0;
            vld_q                   <= 1'b0;
            td_h_active_ctr         <= '0;
            td_h_blank_ctr          <= '0;
            td_h_total_ctr          <= '0;
            td_v_blank_ctr          <= '0;
            td_v_active_ctr         <= '0;
            td_lane_count           <= '0;
            td_tu_vld_data_size     <= '0;
            td_tu_stuffed_data_size <= '0;
        end
        else if (calc_clear)                     // iso start dropped
        begin
            h_seen                  <= 1'b0;
            tu_seen                 <= 1'b0;
            vld_q                   <= 1'b0;
            td_h_active_ctr         <= '0;
            td_h_blank_ctr          <= '0;
            td_h_total_ctr          <= '0;
            td_v_blank_ctr          <= '0;
            td_v_active_ctr         <= '0;
            td_lane_count           <= '0;
            td_tu_vld_data_size     <= '0;
            td_tu_stuffed_data_size <= '0;
        end
        else if (calc_start)                     // new round, keep old values
        begin
            h_seen  <= 1'b0;
            tu_seen <= 1'b0;
            vld_q   <= 1'b0;
        end
        else
        begin
            if (h_done)
                h_seen <= 1'b1;
            if (tu_done)
                tu_seen <= 1'b1;
            if (both_done && !vld_q)             // load once, then hold
            begin
                vld_q                   <= 1'b1;
                td_h_active_ctr         <= hactive_sym;
                td_h_blank_ctr          <= hblank_sym;
                td_h_total_ctr          <= htotal_sym;
                td_v_blank_ctr          <= vblank_full[VBLANK_W-1:0];
                td_v_active_ctr         <= vheight_q[VACTIVE_W-1:0];
                td_lane_count           <= lane_m1[1:0];
                td_tu_vld_data_size     <= tu_valid_size;
                td_tu_stuffed_data_size <= stuff_size;
            end
        end
    end

endmodule

// ==== source/timing_decision_top.sv ====
`timescale 1ns/1ps
// timing decision top level
// capture, horizontal symbol and TU sizing blocks, output stage
module timing_decision_top #(
    parameter int DIV_WIDTH = 20     // TU divider width
)
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                spm_msa_vld,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  htotal,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  hwidth,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  vtotal,
    input  logic [dp_video_pkg::H_WIDTH_W-1:0]  vheight,
    input  logic [7:0]                          misc0,
    input  logic [7:0]                          misc1,
    input  logic                                spm_iso_start,
    input  logic [2:0]                          spm_lane_count,
    input  logic [15:0]                         spm_lane_bw,
    input  logic [9:0]                          ms_stm_bw,
    input  logic                                ms_stm_bw_valid,
    output logic                                td_vld_data,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  td_h_active_ctr,
    output logic [dp_video_pkg::HBLANK_W-1:0]   td_h_blank_ctr,
    output logic [dp_video_pkg::H_WIDTH_W-1:0]  td_h_total_ctr,
    output logic [dp_video_pkg::VBLANK_W-1:0]   td_v_blank_ctr,
    output logic [dp_video_pkg::VACTIVE_W-1:0]  td_v_active_ctr,
    output logic [1:0]                          td_lane_count,
    output logic [dp_link_pkg::TU_W-1:0]        td_tu_vld_data_size,
    output logic [dp_link_pkg::TU_W-1:0]        td_tu_stuffed_data_size
);
    import dp_video_pkg::*;
    import dp_link_pkg::*;

    // captured settings
    logic [H_WIDTH_W-1:0] hwidth_q;
    logic [H_WIDTH_W-1:0] htotal_q;
    logic [H_WIDTH_W-1:0] vtotal_q;
    logic [H_WIDTH_W-1:0] vheight_q;
    logic [15:0]          bytes_per_pixel;
    lane_shift_t          lane_shift;
    logic [15:0]          lane_bw_q;
    logic [9:0]           stream_bw_q;
    logic [2:0]           lane_count_q;
    logic                 calc_start;
    logic                 calc_clear;
    // block results
    logic [H_WIDTH_W-1:0] hactive_sym;
    logic [HBLANK_W-1:0]  hblank_sym;
    logic                 h_done;
    logic [TU_W-1:0]      tu_valid_size;
    logic                 tu_done;

    td_config_capture u_cfg (
        .clk, .rst_n, .spm_msa_vld, .htotal, .hwidth, .vtotal, .vheight,
        .misc0, .misc1, .spm_iso_start, .spm_lane_count, .spm_lane_bw,
        .ms_stm_bw, .ms_stm_bw_valid,
        .hwidth_q, .htotal_q, .vtotal_q, .vheight_q, .bytes_per_pixel,
        .lane_shift, .lane_bw_q, .stream_bw_q, .calc_start, .calc_clear,
        .lane_count_q
    );

    // the two calculations run side by side
    h_symbol_calc u_hsym (
        .clk, .rst_n, .calc_start, .hwidth_q, .htotal_q, .bytes_per_pixel,
        .lane_shift, .hactive_sym, .hblank_sym, .h_done
    );

    tu_size_calc #(
        .DIV_WIDTH (DIV_WIDTH)
    ) u_tu (
        .clk, .rst_n, .calc_start, .stream_bw_q, .lane_bw_q, .bytes_per_pixel,
        .lane_shift, .tu_valid_size, .tu_done
    );

    td_output_stage u_out (
        .clk, .rst_n, .calc_start, .calc_clear, .h_done, .tu_done,
        .hactive_sym, .hblank_sym, .tu_valid_size, .vtotal_q, .vheight_q,
        .lane_count_q, .td_vld_data, .td_h_active_ctr, .td_h_blank_ctr,
        .td_h_total_ctr, .td_v_blank_ctr, .td_v_active_ctr, .td_lane_count,
        .td_tu_vld_data_size, .td_tu_stuffed_data_size
    );

endmodule

// ==== source/tu_size_calc.sv ====
`timescale 1ns/1ps
// transfer unit valid symbol size
// stream_bw*B*64 / (lane_bw*L) through the sequential divider, saturated
module tu_size_calc #(
    parameter int DIV_WIDTH = 20
)
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          calc_start,
    input  logic [9:0]                    stream_bw_q,
    input  logic [15:0]                   lane_bw_q,
    input  logic [15:0]                   bytes_per_pixel,
    input  dp_link_pkg::lane_shift_t      lane_shift,
    output logic [dp_link_pkg::TU_W-1:0]  tu_valid_size,
    output logic                          tu_done
);
    import dp_link_pkg::*;

    logic [31:0]          bw_prod;      // stream symbols per TU, unscaled by lanes
    logic [DIV_WIDTH-1:0] dividend_q;
    logic [DIV_WIDTH-1:0] divisor_q;
    logic                 div_start;
    logic [DIV_WIDTH-1:0] quotient;
    logic                 div_fin;

    assign bw_prod = 32'(stream_bw_q) * 32'(bytes_per_pixel) * 32'(TU_SIZE);

    // operands, divisor is total link bandwidth over all lanes
    always_ff @(posedge clk)
    begin
        if (calc_start)
        begin
            dividend_q <= DIV_WIDTH'(bw_prod);
            divisor_q  <= DIV_WIDTH'(lane_bw_q) << lane_shift;
        end
        if (div_fin)                          // clamp to a full TU
            tu_valid_size <= (quotient > DIV_WIDTH'(TU_SIZE - 1)) ?
                             TU_W'(TU_SIZE - 1) : quotient[TU_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_start <= 1'b0;
            tu_done   <= 1'b0;
        end
        else
        begin
            div_start <= calc_start;          // operands valid one cycle later
            tu_done   <= div_fin;
        end
    end

    seq_divider #(
        .WIDTH (DIV_WIDTH)
    ) u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (dividend_q),
        .divisor  (divisor_q),
        .quotient (quotient),
        .done     (div_fin)
    );

endmodule

// ==== verif/tb_timing_decision.sv ====
`timescale 1ns/1ps
// testbench for the timing decision top level
// directed tests for symbol counts, vertical counts and TU sizing,
// restart and clear behaviour, closing error report
module tb_timing_decision;

    logic        clk;
    logic        rst_n;
    logic        spm_msa_vld;
    logic [15:0] htotal;
    logic [15:0] hwidth;
    logic [15:0] vtotal;
    logic [15:0] vheight;
    logic [7:0]  misc0;
    logic [7:0]  misc1;
    logic        spm_iso_start;
    logic [2:0]  spm_lane_count;
    logic [15:0] spm_lane_bw;
    logic [9:0]  ms_stm_bw;
    logic        ms_stm_bw_valid;
    logic        td_vld_data;
    logic [15:0] td_h_active_ctr;
    logic [13:0] td_h_blank_ctr;
    logic [15:0] td_h_total_ctr;
    logic [9:0]  td_v_blank_ctr;
    logic [12:0] td_v_active_ctr;
    logic [1:0]  td_lane_count;
    logic [5:0]  td_tu_vld_data_size;
    logic [5:0]  td_tu_stuffed_data_size;

    integer seed;
    int     value_errors;
    int     timeout_errors;
    // stream setup the reference model works from
    int     cur_hw;
    int     cur_ht;
    int     cur_vt;
    int     cur_vh;
    int     cur_b;      // symbols per pixel
    int     cur_l;      // lanes
    int     cur_lbw;
    int     cur_sbw;

    timing_decision_top #(
        .DIV_WIDTH (20)
    ) u_dut (.*);

    bind td_output_stage timing_decision_assertions u_chk (
        .clk, .rst_n, .calc_start, .calc_clear, .td_vld_data, .td_h_active_ctr,
        .td_h_blank_ctr, .td_h_total_ctr, .td_v_blank_ctr, .td_v_active_ctr,
        .td_lane_count, .td_tu_vld_data_size, .td_tu_stuffed_data_size
    );

    always #10 clk = ~clk;     // 20 ns period

    //==================================================
    // reference model and helpers
    //==================================================
    function automatic int symbols_per_pixel(input logic [7:0] m0, input logic [7:0] m1);
        logic [8:0] code;
        code = {m1[7:6], m0[7:1]};
        if (code == 9'h040 || code == 9'h046)
            return 6;           // 16 bpc rgb or ycbcr 4:4:4
        return 3;               // everything else is 8 bpc
    endfunction

    function automatic int ceil_div(input int num, input int den);
        return (num + den - 1) / den;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;                     // drive point after the edge
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    // bounded wait for td_vld_data to reach a level
    task automatic wait_vld(input logic level, output bit ok);
        int cnt;
        ok  = 1'b0;
        cnt = 0;
        while (!ok && cnt < 200)
        begin
            if (td_vld_data === level)
                ok = 1'b1;
            else
            begin
                step();
                cnt++;
            end
        end
        if (!ok)
        begin
            $display("timeout, td_vld_data did not go to %0d within 200 cycles", level);
            timeout_errors++;
        end
    endtask

    // drop iso start, load attributes and bandwidths, raise iso start again
    task automatic start_stream(input int hw, input int ht, input int vt, input int vh,
                                input logic [7:0] m0, input logic [7:0] m1,
                                input int lanes, input int lbw, input int sbw);
        spm_iso_start   = 1'b0;        // lane settings only load on the rising edge
        step();
        hwidth          = 16'(hw);
        htotal          = 16'(ht);
        vtotal          = 16'(vt);
        vheight         = 16'(vh);
        misc0           = m0;
        misc1           = m1;
        spm_lane_count  = 3'(lanes);
        spm_lane_bw     = 16'(lbw);
        ms_stm_bw       = 10'(sbw);
        spm_msa_vld     = 1'b1;
        ms_stm_bw_valid = 1'b1;
        step();
        spm_msa_vld     = 1'b0;
        ms_stm_bw_valid = 1'b0;
        spm_iso_start   = 1'b1;
        cur_hw  = hw;
        cur_ht  = ht;
        cur_vt  = vt;
        cur_vh  = vh;
        cur_b   = symbols_per_pixel(m0, m1);
        cur_l   = lanes;
        cur_lbw = lbw;
        cur_sbw = sbw;
    endtask

    task automatic check_results();
        int act;
        int blk;
        int tu;
        act = ceil_div(cur_hw, cur_l) * cur_b;
        blk = ceil_div(cur_ht - cur_hw, cur_l) * cur_b;
        tu  = (cur_sbw * cur_b * 64) / (cur_l * cur_lbw);
        if (tu > 63)
            tu = 63;                   // a TU holds at most 63 valid symbols
        check_val("td_h_active_ctr", td_h_active_ctr, act);
        check_val("td_h_blank_ctr", td_h_blank_ctr, blk);
        check_val("td_h_total_ctr", td_h_total_ctr, act + blk);
        check_val("td_v_blank_ctr", td_v_blank_ctr, cur_vt - cur_vh);
        check_val("td_v_active_ctr", td_v_active_ctr, cur_vh);
        check_val("td_lane_count", td_lane_count, cur_l - 1);
        check_val("td_tu_vld_data_size", td_tu_vld_data_size, tu);
        check_val("td_tu_stuffed_data_size", td_tu_stuffed_data_size, 64 - tu);
    endtask

    task automatic check_zero();
        check_val("td_vld_data", td_vld_data, 0);
        check_val("td_h_active_ctr", td_h_active_ctr, 0);
        check_val("td_h_blank_ctr", td_h_blank_ctr, 0);
        check_val("td_h_total_ctr", td_h_total_ctr, 0);
        check_val("td_v_blank_ctr", td_v_blank_ctr, 0);
        check_val("td_v_active_ctr", td_v_active_ctr, 0);
        check_val("td_lane_count", td_lane_count, 0);
        check_val("td_tu_vld_data_size", td_tu_vld_data_size, 0);
        check_val("td_tu_stuffed_data_size", td_tu_stuffed_data_size, 0);
    endtask

    //==================================================
    // directed tests
    //==================================================
    task automatic test_rgb8_four_lanes();
        bit ok;
        start_stream(1920, 2200, 1125, 1080, 8'h20, 8'h00, 4, 540, 300);
        wait_vld(1'b1, ok);
        if (ok)
            check_results();
    endtask

    // odd active and blanking widths exercise the round up
    task automatic test_ycc16_two_lanes();
        bit ok;
        start_stream(1365, 1526, 806, 768, 8'h8c, 8'h00, 2, 540, 100);
        wait_vld(1'b1, ok);
        if (ok)
            check_results();
    endtask

    task automatic test_tu_sweep();
        bit ok;
        int sbw;
        int lanes;
        for (int li = 0; li < 3; li++)
        begin
            lanes = 1 << li;
            for (int n = 0; n < 8; n++)
            begin
                sbw = 16 + {$random(seed)} % 600;   // never below one valid symbol
                start_stream(1280, 1650, 750, 720, (n[0] ? 8'h80 : 8'h20), 8'h00,
                             lanes, 540, sbw);
                wait_vld(1'b1, ok);
                if (ok)
                    check_results();
            end
        end
    endtask

    task automatic test_restart_and_clear();
        bit ok;
        start_stream(800, 1056, 628, 600, 8'h20, 8'h00, 2, 540, 200);
        wait_vld(1'b1, ok);
        // new attributes while held with the lanes unchanged
        hwidth      = 16'd1024;
        htotal      = 16'd1344;
        vtotal      = 16'd806;
        vheight     = 16'd768;
        misc0       = 8'h80;           // rgb 16 bpc
        spm_msa_vld = 1'b1;
        step();
        spm_msa_vld = 1'b0;
        cur_hw = 1024;
        cur_ht = 1344;
        cur_vt = 806;
        cur_vh = 768;
        cur_b  = symbols_per_pixel(8'h80, 8'h00);
        wait_vld(1'b0, ok);
        wait_vld(1'b1, ok);
        if (ok)
            check_results();
        spm_iso_start = 1'b0;          // clear path
        wait_vld(1'b0, ok);
        if (ok)
            check_zero();
    endtask

    initial
    begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        spm_msa_vld     = 1'b0;
        htotal          = '0;
        hwidth          = '0;
        vtotal          = '0;
        vheight         = '0;
        misc0           = '0;
        misc1           = '0;
        spm_iso_start   = 1'b0;
        spm_lane_count  = 3'd1;
        spm_lane_bw     = '0;
        ms_stm_bw       = '0;
        ms_stm_bw_valid = 1'b0;
        seed            = 26710;
        value_errors    = 0;
        timeout_errors  = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step();
        check_zero();                  // state straight out of reset
        test_rgb8_four_lanes();
        test_ycc16_two_lanes();
        test_tu_sweep();
        test_restart_and_clear();
        step();
        $display("value errors %0d, timeouts %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== verif/timing_decision_assertions.sv ====
`timescale 1ns/1ps
// concurrent checks bound into the output stage
// full TU size sum, clear behaviour, valid low during a restart
module timing_decision_assertions
(
    input logic                                clk,
    input logic                                rst_n,
    input logic                                calc_start,
    input logic                                calc_clear,
    input logic                                td_vld_data,
    input logic [dp_video_pkg::H_WIDTH_W-1:0]  td_h_active_ctr,
    input logic [dp_video_pkg::HBLANK_W-1:0]   td_h_blank_ctr,
    input logic [dp_video_pkg::H_WIDTH_W-1:0]  td_h_total_ctr,
    input logic [dp_video_pkg::VBLANK_W-1:0]   td_v_blank_ctr,
    input logic [dp_video_pkg::VACTIVE_W-1:0]  td_v_active_ctr,
    input logic [1:0]                          td_lane_count,
    input logic [dp_link_pkg::TU_W-1:0]        td_tu_vld_data_size,
    input logic [dp_link_pkg::TU_W-1:0]        td_tu_stuffed_data_size
);
    import dp_link_pkg::*;

    // valid and stuffed parts fill one transfer unit
    tu_fill: assert property (@(posedge clk) disable iff (!rst_n)
        td_vld_data |->
            (7'(td_tu_vld_data_size) + 7'(td_tu_stuffed_data_size) == 7'(TU_SIZE)))
        else $error("valid plus stuffed size differs from the TU size");

    // iso start low wipes everything on the next edge
    clear_zero: assert property (@(posedge clk) disable iff (!rst_n)
        calc_clear |=> (!td_vld_data && td_h_active_ctr == '0 && td_h_blank_ctr == '0 &&
                        td_h_total_ctr == '0 && td_v_blank_ctr == '0 &&
                        td_v_active_ctr == '0 && td_lane_count == '0 &&
                        td_tu_vld_data_size == '0 && td_tu_stuffed_data_size == '0))
        else $error("outputs not cleared one cycle after calc_clear");

    // restart hides stale results in the start cycle and the one after
    no_vld_on_start: assert property (@(posedge clk) disable iff (!rst_n)
        (calc_start || $past(calc_start)) |-> !td_vld_data)
        else $error("td_vld_data high during or just after calc_start");

endmodule
